//--- src/axiLiteMemPort.sv
// AXI4-Lite slave front end, serializes bus transactions into single-cycle memory requests
`default_nettype none

module axiLiteMemPort
   import memPkg::*;
(
   input  logic                    clk_i,         // Clock
   input  logic                    rst_ni,        // Async reset, active low
   // AW channel
   input  logic [AxiAddrWidth-1:0] awaddr_i,
   input  logic                    awvalid_i,
   output logic                    awready_o,
   // W channel
   input  logic [DataWidth-1:0]    wdata_i,
   input  logic [BeWidth-1:0]      wstrb_i,
   input  logic                    wvalid_i,
   output logic                    wready_o,
   // B channel
   output axiResp_e                bresp_o,
   output logic                    bvalid_o,
   input  logic                    bready_i,
   // AR channel
   input  logic [AxiAddrWidth-1:0] araddr_i,
   input  logic                    arvalid_i,
   output logic                    arready_o,
   // R channel
   output logic [DataWidth-1:0]    rdata_o,
   output axiResp_e                rresp_o,
   output logic                    rvalid_o,
   input  logic                    rready_i,
   // Memory request side
   output logic                    memReq_o,      // One cycle request
   output logic                    memWe_o,       // Write enable
   output logic [AddrWidth-1:0]    memAddr_o,     // Word address
   output logic [DataWidth-1:0]    memWdata_o,    // Write data
   output logic [BeWidth-1:0]      memBe_o,       // Byte enables from wstrb
   input  logic [DataWidth-1:0]    memRdata_i,    // Read data, one cycle after request
   input  logic                    memBankOff_i   // Bank was off at the request
);

   portState_e state;    // Transaction phase
   logic       awHsk;    // AW and W transfer this edge
   logic       arHsk;    // AR transfer this edge
   logic       wrPend;   // Write side asking, blocks reads

   // Handshakes only happen in idle, readies are low elsewhere
   assign awHsk  = awready_o & awvalid_i & wready_o & wvalid_i;
   assign arHsk  = arready_o & arvalid_i;
   assign wrPend = awvalid_i | wvalid_i;

   // Memory request is the single cycle after acceptance
   assign memReq_o = (state == StWrite) || (state == StRead);
   assign memWe_o  = (state == StWrite);

   // Control FSM
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state     <= StIdle;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         arready_o <= 1'b0;
         bvalid_o  <= 1'b0;
         rvalid_o  <= 1'b0;
      end else begin
         case (state)
            StIdle: begin
               if (awHsk) begin                      // Write accepted
                  awready_o <= 1'b0;
                  wready_o  <= 1'b0;
                  state     <= StWrite;
               end else if (arHsk) begin             // Read accepted
                  arready_o <= 1'b0;
                  state     <= StRead;
               end else if (awvalid_i && wvalid_i) begin
                  awready_o <= 1'b1;                 // Both write channels up, write wins
                  wready_o  <= 1'b1;
                  arready_o <= 1'b0;                 // Drop a read offer still pending
               end else if (arvalid_i && !wrPend) begin
                  arready_o <= 1'b1;
               end
            end
            StWrite: state <= StBResp;               // Memory sees the write here
            StRead:  state <= StRResp;               // Memory sees the read here
            StBResp: begin
               if (!bvalid_o) begin
                  bvalid_o <= 1'b1;                  // Flag sampled, response up
               end else if (bready_i) begin
                  bvalid_o <= 1'b0;
                  state    <= StIdle;
               end
            end
            StRResp: begin
               if (!rvalid_o) begin
                  rvalid_o <= 1'b1;                  // Data captured, response up
               end else if (rready_i) begin
                  rvalid_o <= 1'b0;
                  state    <= StIdle;
               end
            end
            default: state <= StIdle;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk_i) begin
      if (awHsk) begin
         memAddr_o  <= awaddr_i[AxiAddrWidth-1 -: AddrWidth];  // Drop byte offset
         memWdata_o <= wdata_i;
         memBe_o    <= wstrb_i;                               // Strobe maps 1:1 to lanes
      end else if (arHsk) begin
         memAddr_o  <= araddr_i[AxiAddrWidth-1 -: AddrWidth];
         memBe_o    <= '0;                                    // No lanes on a read
      end
      // Held under back-pressure, only loaded once per response
      if (state == StBResp && !bvalid_o) begin
         bresp_o <= memBankOff_i ? RespSlvErr : RespOkay;
      end
      if (state == StRResp && !rvalid_o) begin
         rdata_o <= memRdata_i;                               // Zero from an off bank
         rresp_o <= memBankOff_i ? RespSlvErr : RespOkay;
      end
   end

endmodule : axiLiteMemPort

`default_nettype wire

//--- src/memMultibankPwrgate.sv
// Multibank scratchpad memory, splits the word space into contiguous banks powered on their own
`default_nettype none

module memMultibankPwrgate
   import memPkg::*;
(
   input  logic                 clk_i,        // Clock
   input  logic                 rst_ni,       // Async reset, active low
   input  logic                 req_i,        // Access request
   input  logic                 we_i,         // Write enable
   input  logic [AddrWidth-1:0] addr_i,       // Word address over the whole memory
   input  logic [DataWidth-1:0] wdata_i,      // Write data
   input  logic [BeWidth-1:0]   be_i,         // Byte enables
   input  logic [NumBanks-1:0]  deepSleep_i,  // Per bank retention
   input  logic [NumBanks-1:0]  powerGate_i,  // Per bank supply off
   output logic [DataWidth-1:0] rdata_o,      // Read data, one cycle after req
   output logic                 bankOff_o     // Addressed bank was off at the request
);

   // Bank selection
   logic [BankSelWidth-1:0] bankSel;   // Bank of the current request
   logic [BankSelWidth-1:0] bankSelQ;  // Bank of the request in flight

   // Per bank request side
   logic [NumBanks-1:0]      reqCut;
   logic [NumBanks-1:0]      weCut;
   logic [BankAddrWidth-1:0] addrCut  [NumBanks];
   logic [DataWidth-1:0]     wdataCut [NumBanks];
   logic [BeWidth-1:0]       beCut    [NumBanks];

   // Per bank response side
   logic [DataWidth-1:0]     rdataCut [NumBanks];
   logic [NumBanks-1:0]      offCut;

   // Top address bits pick the bank, so each bank is one contiguous slice
   assign bankSel = addr_i[AddrWidth-1 -: BankSelWidth];

   // Remember which bank answers next cycle
   // Only moves on a request so the output stays put between accesses
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         bankSelQ <= '0;
      end else if (req_i) begin
         bankSelQ <= bankSel;
      end
   end

   // Return path mux, steered by the delayed select
   assign rdata_o   = rdataCut[bankSelQ];
   assign bankOff_o = offCut[bankSelQ];

   for (genvar gBank = 0; gBank < NumBanks; gBank++) begin : genBank
      // Demux, idle banks see all zero inputs
      assign reqCut[gBank]   = req_i && (bankSel == BankSelWidth'(gBank));
      assign weCut[gBank]    = reqCut[gBank] ? we_i : 1'b0;
      assign addrCut[gBank]  = reqCut[gBank] ? addr_i[BankAddrWidth-1:0] : '0;  // Low bits only
      assign wdataCut[gBank] = reqCut[gBank] ? wdata_i : '0;
      assign beCut[gBank]    = reqCut[gBank] ? be_i : '0;

      sramBank i_sramBank (
         .clk_i       (clk_i),
         .rst_ni      (rst_ni),
         .req_i       (reqCut[gBank]),
         .we_i        (weCut[gBank]),
         .addr_i      (addrCut[gBank]),
         .wdata_i     (wdataCut[gBank]),
         .be_i        (beCut[gBank]),
         .deepSleep_i (deepSleep_i[gBank]),  // Own power controls per bank
         .powerGate_i (powerGate_i[gBank]),
         .rdata_o     (rdataCut[gBank]),
         .off_o       (offCut[gBank])
      );
   end : genBank

endmodule : memMultibankPwrgate

`default_nettype wire

//--- src/memPkg.sv
// Scratchpad subsystem package with memory geometry, AXI response codes and port states
`default_nettype none

package memPkg;

   // Whole memory geometry
   localparam int unsigned NumWords     = 256;             // Data words over all banks
   localparam int unsigned DataWidth    = 32;              // Word width
   localparam int unsigned ByteWidth    = 8;               // Byte lane width
   localparam int unsigned BeWidth      = DataWidth / ByteWidth;  // Byte lanes per word
   localparam int unsigned AddrWidth    = $clog2(NumWords);       // Word address width

   // Logic bank split, banks take contiguous slices by top address bits
   localparam int unsigned NumBanks      = 4;
   localparam int unsigned BankSelWidth  = $clog2(NumBanks);      // Top bits picking the bank
   localparam int unsigned BankWords     = NumWords / NumBanks;   // Words in one bank
   localparam int unsigned BankAddrWidth = AddrWidth - BankSelWidth;

   // Bus side byte address, two extra bits for the byte offset
   localparam int unsigned AxiAddrWidth = AddrWidth + 2;

   // AXI response codes, only the two used here
   typedef enum logic [1:0] {
      RespOkay   = 2'b00,  // Normal access
      RespSlvErr = 2'b10   // Addressed bank asleep or gated
   } axiResp_e;

   // Front end states
   typedef enum logic [2:0] {
      StIdle,   // Waiting for AW+W or AR
      StWrite,  // Memory write issued
      StRead,   // Memory read issued
      StBResp,  // Write response phase
      StRResp   // Read response phase
   } portState_e;

endpackage : memPkg

`default_nettype wire

//--- src/memSubsysTop.sv
// Power-managed scratchpad subsystem, AXI4-Lite front end joined to the multibank memory
`default_nettype none

module memSubsysTop
   import memPkg::*;
(
   input  logic                    clk_i,        // Clock
   input  logic                    rst_ni,       // Async reset, active low
   input  logic [AxiAddrWidth-1:0] awaddr_i,
   input  logic                    awvalid_i,
   output logic                    awready_o,
   input  logic [DataWidth-1:0]    wdata_i,
   input  logic [BeWidth-1:0]      wstrb_i,
   input  logic                    wvalid_i,
   output logic                    wready_o,
   output axiResp_e                bresp_o,
   output logic                    bvalid_o,
   input  logic                    bready_i,
   input  logic [AxiAddrWidth-1:0] araddr_i,
   input  logic                    arvalid_i,
   output logic                    arready_o,
   output logic [DataWidth-1:0]    rdata_o,
   output axiResp_e                rresp_o,
   output logic                    rvalid_o,
   input  logic                    rready_i,
   input  logic [NumBanks-1:0]     deepSleep_i,  // Stand-ins for supply controls
   input  logic [NumBanks-1:0]     powerGate_i
);

   // Front end to memory link
   logic                 memReq;
   logic                 memWe;
   logic [AddrWidth-1:0] memAddr;
   logic [DataWidth-1:0] memWdata;
   logic [BeWidth-1:0]   memBe;
   logic [DataWidth-1:0] memRdata;
   logic                 memBankOff;

   axiLiteMemPort i_axiPort (
      .clk_i, .rst_ni,
      .awaddr_i, .awvalid_i, .awready_o,
      .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
      .bresp_o, .bvalid_o, .bready_i,
      .araddr_i, .arvalid_i, .arready_o,
      .rdata_o, .rresp_o, .rvalid_o, .rready_i,
      .memReq_o     (memReq),
      .memWe_o      (memWe),
      .memAddr_o    (memAddr),
      .memWdata_o   (memWdata),
      .memBe_o      (memBe),
      .memRdata_i   (memRdata),
      .memBankOff_i (memBankOff)
   );

   memMultibankPwrgate i_mem (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (memReq),
      .we_i        (memWe),
      .addr_i      (memAddr),
      .wdata_i     (memWdata),
      .be_i        (memBe),
      .deepSleep_i (deepSleep_i),
      .powerGate_i (powerGate_i),
      .rdata_o     (memRdata),
      .bankOff_o   (memBankOff)
   );

endmodule : memSubsysTop

`default_nettype wire

//--- src/sramBank.sv
// Logic bank of the scratchpad with byte-enable writes, retention sleep and supply gating
`default_nettype none

module sramBank
   import memPkg::*;
(
   input  logic                     clk_i,        // Clock
   input  logic                     rst_ni,       // Async reset, active low
   input  logic                     req_i,        // Access request
   input  logic                     we_i,         // Write when set, read otherwise
   input  logic [BankAddrWidth-1:0] addr_i,       // Word address inside the bank
   input  logic [DataWidth-1:0]     wdata_i,      // Write data
   input  logic [BeWidth-1:0]       be_i,         // Byte enables
   input  logic                     deepSleep_i,  // Retention, contents kept
   input  logic                     powerGate_i,  // Supply off, contents lost
   output logic [DataWidth-1:0]     rdata_o,      // Read data, one cycle after req
   output logic                     off_o         // Bank was off at the request
);

   logic [DataWidth-1:0] memArray [BankWords];  // Bank storage
   logic                 bankOff;               // Bank not reachable this cycle

   // Either low power state blocks the access
   assign bankOff = deepSleep_i | powerGate_i;

   // Storage update
   // Gating wins over everything, it models the array losing its supply
   always_ff @(posedge clk_i) begin
      if (powerGate_i) begin
         for (int w = 0; w < BankWords; w++) begin
            memArray[w] <= '0;                  // Contents gone
         end
      end else if (req_i && we_i && !deepSleep_i) begin
         for (int b = 0; b < BeWidth; b++) begin
            if (be_i[b]) begin  // Only enabled lanes change
               memArray[addr_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
            end
         end
      end
   end

   // Off flag follows each request, held between requests
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         off_o <= 1'b0;
      end else if (req_i) begin
         off_o <= bankOff;  // Power state seen at the request edge
      end
   end

   // Registered read port, zero while the bank is off
   always_ff @(posedge clk_i) begin
      if (req_i) begin
         rdata_o <= bankOff ? '0 : memArray[addr_i];
      end
   end

endmodule : sramBank

`default_nettype wire

//--- tb.f
src/memPkg.sv
src/sramBank.sv
src/memMultibankPwrgate.sv
src/axiLiteMemPort.sv
src/memSubsysTop.sv
verification/tbClkGen.sv
verification/memSubsysTb.sv

//--- verification/memSubsysTb.sv
// Testbench for the power-managed scratchpad, AXI4-Lite traffic checked against a word model
`default_nettype none

module memSubsysTb
   import memPkg::*;
();

   localparam int unsigned NumTrans   = 81;                  // Bus transactions over all tests
   localparam int unsigned CycleLimit = 20 * NumTrans + 200;

   logic                    clk_i;
   logic                    rst_ni;
   logic [AxiAddrWidth-1:0] awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [DataWidth-1:0]    wdata;
   logic [BeWidth-1:0]      wstrb;
   logic                    wvalid;
   logic                    wready;
   axiResp_e                bresp;
   logic                    bvalid;
   logic                    bready;
   logic [AxiAddrWidth-1:0] araddr;
   logic                    arvalid;
   logic                    arready;
   logic [DataWidth-1:0]    rdata;
   axiResp_e                rresp;
   logic                    rvalid;
   logic                    rready;
   logic [NumBanks-1:0]     deepSleep;
   logic [NumBanks-1:0]     powerGate;

   logic [DataWidth-1:0] shadowMem [NumWords];  // Expected memory contents
   logic [DataWidth-1:0] expRData [$];          // Pending read data, in issue order
   axiResp_e             expRResp [$];
   axiResp_e             expBResp [$];
   logic [AddrWidth-1:0] addrList [16];         // Words spread over all banks
   integer               seed = 40;
   int unsigned          cycleCount = 0;
   int unsigned          dataErrs = 0;
   int unsigned          respErrs = 0;
   int unsigned          otherErrs = 0;

   tbClkGen i_clkGen (.clk_o(clk_i), .rst_no(rst_ni));

   memSubsysTop i_dut (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .awaddr_i    (awaddr),
      .awvalid_i   (awvalid),
      .awready_o   (awready),
      .wdata_i     (wdata),
      .wstrb_i     (wstrb),
      .wvalid_i    (wvalid),
      .wready_o    (wready),
      .bresp_o     (bresp),
      .bvalid_o    (bvalid),
      .bready_i    (bready),
      .araddr_i    (araddr),
      .arvalid_i   (arvalid),
      .arready_o   (arready),
      .rdata_o     (rdata),
      .rresp_o     (rresp),
      .rvalid_o    (rvalid),
      .rready_i    (rready),
      .deepSleep_i (deepSleep),
      .powerGate_i (powerGate)
   );

   task automatic checkData(input string name, input logic [DataWidth-1:0] expv,
                            input logic [DataWidth-1:0] actv);
      if (actv !== expv) begin
         dataErrs++;
         $display("FAIL %s expected %h got %h", name, expv, actv);
      end
   endtask

   task automatic checkResp(input string name, input axiResp_e expv, input axiResp_e actv);
      if (actv !== expv) begin
         respErrs++;
         $display("FAIL %s expected %h got %h", name, expv, actv);
      end
   endtask

   // Expected read result, bank taken from the top word address bits
   function automatic void refRead(input logic [AddrWidth-1:0] wordAddr,
                                   output logic [DataWidth-1:0] expData,
                                   output axiResp_e expResp);
      logic [BankSelWidth-1:0] bank;
      bank = wordAddr[AddrWidth-1 -: BankSelWidth];
      if (deepSleep[bank] || powerGate[bank]) begin
         expData = '0;          // Off bank returns zero
         expResp = RespSlvErr;
      end else begin
         expData = shadowMem[wordAddr];
         expResp = RespOkay;
      end
   endfunction

   // Byte merge into the model, only for an awake bank
   function automatic axiResp_e refWrite(input logic [AddrWidth-1:0] wordAddr,
                                         input logic [DataWidth-1:0] data,
                                         input logic [BeWidth-1:0] strb);
      logic [BankSelWidth-1:0] bank;
      bank = wordAddr[AddrWidth-1 -: BankSelWidth];
      if (deepSleep[bank] || powerGate[bank]) begin
         return RespSlvErr;
      end
      for (int b = 0; b < BeWidth; b++) begin
         if (strb[b]) begin
            shadowMem[wordAddr][b*ByteWidth +: ByteWidth] = data[b*ByteWidth +: ByteWidth];
         end
      end
      return RespOkay;
   endfunction

   task automatic nextCycle();
      @(posedge clk_i);
      #2;  // Drive point after the edge
   endtask

   // Power change, a rising gate bit wipes that bank in the model
   task automatic setPower(input logic [NumBanks-1:0] sleep, input logic [NumBanks-1:0] gate);
      for (int b = 0; b < NumBanks; b++) begin
         if (gate[b] && !powerGate[b]) begin
            for (int w = 0; w < BankWords; w++) shadowMem[b*BankWords + w] = '0;
         end
      end
      deepSleep = sleep;
      powerGate = gate;
   endtask

   task automatic checkReadiesLow();
      if (awready || wready || arready) begin
         otherErrs++;
         $display("A ready output went high while a response was still pending");
      end
   endtask

   task automatic waitWriteAccept();
      logic hsk;
      hsk = 1'b0;
      while (!hsk) begin
         hsk = awready && wready;  // Transfer on the coming edge
         if (arready) begin
            otherErrs++;
            $display("Read channel accepted while a write was pending");
         end
         nextCycle();
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic waitReadAccept();
      logic hsk;
      hsk = 1'b0;
      while (!hsk) begin
         hsk = arready;
         nextCycle();
      end
      arvalid = 1'b0;
   endtask

   // B phase, bready held low for a number of cycles first
   task automatic takeB(input int stall);
      axiResp_e first;
      while (!bvalid) nextCycle();
      first = bresp;
      repeat (stall) begin
         nextCycle();
         if (!bvalid) begin
            otherErrs++;
            $display("Write response dropped while bready was low");
         end
         checkResp("bresp", first, bresp);  // Must hold still
         checkReadiesLow();
      end
      bready = 1'b1;
      nextCycle();
      bready = 1'b0;
   endtask

   task automatic takeR(input int stall);
      logic [DataWidth-1:0] firstData;
      axiResp_e             firstResp;
      while (!rvalid) nextCycle();
      firstData = rdata;
      firstResp = rresp;
      repeat (stall) begin
         nextCycle();
         if (!rvalid) begin
            otherErrs++;
            $display("Read response dropped while rready was low");
         end
         checkData("rdata", firstData, rdata);
         checkResp("rresp", firstResp, rresp);
         checkReadiesLow();
      end
      rready = 1'b1;
      nextCycle();
      rready = 1'b0;
   endtask

   // Raise AW and W, model updated at once
   task automatic offerWrite(input logic [AddrWidth-1:0] wordAddr,
                             input logic [DataWidth-1:0] data, input logic [BeWidth-1:0] strb);
      expBResp.push_back(refWrite(wordAddr, data, strb));
      awaddr  = {wordAddr, 2'b00};
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
   endtask

   // Raise AR, expected result taken from the model as it stands
   task automatic offerRead(input logic [AddrWidth-1:0] wordAddr);
      logic [DataWidth-1:0] expData;
      axiResp_e             expResp;
      refRead(wordAddr, expData, expResp);
      expRData.push_back(expData);
      expRResp.push_back(expResp);
      araddr  = {wordAddr, 2'b00};
      arvalid = 1'b1;
   endtask

   task automatic axiWrite(input logic [AddrWidth-1:0] wordAddr, input logic [DataWidth-1:0] data,
                           input logic [BeWidth-1:0] strb, input int stall);
      offerWrite(wordAddr, data, strb);
      waitWriteAccept();
      takeB(stall);
   endtask

   task automatic axiRead(input logic [AddrWidth-1:0] wordAddr, input int stall);
      offerRead(wordAddr);
      waitReadAccept();
      takeR(stall);
   endtask

   // All three address channels raised together, write goes first
   task automatic simulWriteRead(input logic [AddrWidth-1:0] wordAddr,
                                 input logic [DataWidth-1:0] data, input logic [BeWidth-1:0] strb);
      offerWrite(wordAddr, data, strb);
      offerRead(wordAddr);  // Sees the new word
      waitWriteAccept();
      takeB(0);
      waitReadAccept();
      takeR(0);
   endtask

   // Response checker, samples mid cycle before the transfer edge
   always @(negedge clk_i) begin
      if (rst_ni && bvalid && bready) begin
         if (expBResp.size() == 0) begin
            otherErrs++;
            $display("Write response arrived with no write outstanding");
         end else checkResp("bresp", expBResp.pop_front(), bresp);
      end
      if (rst_ni && rvalid && rready) begin
         if (expRData.size() == 0) begin
            otherErrs++;
            $display("Read response arrived with no read outstanding");
         end else begin
            checkData("rdata", expRData.pop_front(), rdata);
            checkResp("rresp", expRResp.pop_front(), rresp);
         end
      end
   end

   // Watchdog
   always @(posedge clk_i) begin
      cycleCount++;
      if (cycleCount >= CycleLimit) begin
         $display("Timeout, run went past %0d cycles", CycleLimit);
         $display("tests failed");
         $finish;
      end
   end

   initial begin
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      deepSleep = '0;
      powerGate = '0;
      for (int i = 0; i < NumWords; i++) shadowMem[i] = 'x;  // Unwritten words unknown
      for (int i = 0; i < 16; i++) addrList[i] = AddrWidth'(i * 16 + 5);  // Four per bank
      @(posedge rst_ni);
      nextCycle();

      // 1 Full words over every bank, read back in a shuffled order
      for (int i = 0; i < 16; i++) axiWrite(addrList[i], $random(seed), 4'hF, 0);
      for (int i = 0; i < 16; i++) axiRead(addrList[(i * 5) % 16], 0);

      // 2 Random strobes on known words
      for (int i = 0; i < 8; i++) begin
         axiWrite(addrList[i * 2], $random(seed), BeWidth'($random(seed)), 0);
      end
      for (int i = 0; i < 8; i++) axiRead(addrList[i * 2], 0);

      // 3 Bank 1 in retention
      setPower(4'b0010, 4'b0000);
      axiRead(addrList[4], 0);
      axiRead(addrList[5], 0);
      axiWrite(addrList[6], $random(seed), 4'hF, 0);  // Blocked
      axiRead(addrList[0], 0);
      axiRead(addrList[8], 0);
      setPower(4'b0000, 4'b0000);
      for (int i = 4; i < 7; i++) axiRead(addrList[i], 0);  // Retained

      // 4 Bank 2 gated for a few cycles
      setPower(4'b0000, 4'b0100);
      repeat (3) nextCycle();
      axiRead(addrList[8], 0);
      axiWrite(addrList[9], $random(seed), 4'hF, 0);
      setPower(4'b0000, 4'b0000);
      for (int i = 8; i < 12; i++) axiRead(addrList[i], 0);  // Cleared
      axiRead(addrList[1], 0);
      axiRead(addrList[5], 0);
      axiRead(addrList[13], 0);

      // 5 Responses held back by the master, next transaction offered meanwhile
      offerWrite(AddrWidth'(200), $random(seed), 4'hF);
      waitWriteAccept();
      for (int i = 0; i < 6; i++) begin
         offerRead(AddrWidth'(200 + i));  // Must wait behind the held write response
         takeB(1 + ($random(seed) & 7));
         waitReadAccept();
         if (i < 5) begin
            offerWrite(AddrWidth'(201 + i), $random(seed), 4'hF);  // Waits behind rvalid
         end
         takeR(1 + ($random(seed) & 7));
         if (i < 5) begin
            waitWriteAccept();
         end
      end

      // 6 Write and read raised together
      simulWriteRead(addrList[2], $random(seed), 4'hF);
      simulWriteRead(addrList[14], $random(seed), 4'b0101);

      repeat (2) nextCycle();
      if (expBResp.size() != 0 || expRData.size() != 0) begin
         otherErrs++;
         $display("Some expected responses never arrived");
      end
      $display("Errors: %0d data, %0d response, %0d other", dataErrs, respErrs, otherErrs);
      if (dataErrs + respErrs + otherErrs == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule : memSubsysTb

`default_nettype wire

//--- verification/tbClkGen.sv
// Testbench clock and reset source, 20 unit period with reset held for three cycles
`default_nettype none

module tbClkGen (
   output logic clk_o,   // Free running clock
   output logic rst_no   // Active low reset
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;  // Half period
      end
   end

   initial begin
      rst_no = 1'b0;
      repeat (3) @(posedge clk_o);
      #2 rst_no = 1'b1;       // Release off the edge, like the stimulus
   end

endmodule : tbClkGen

`default_nettype wire
